/* compile.f */
verilog/video_pkg.sv
verilog/port_decoder.sv
verilog/video_ports.sv
verilog/raster_timer.sv
verilog/scroll_addr.sv
verilog/video_ctrl_top.sv
test/video_ctrl_checker.sv
test/video_ctrl_tb.sv

/* run.sh */
#!/bin/bash
cd "$(dirname "$0")" || exit 1
verilator --binary -f compile.f --top-module video_ctrl_tb \
    && ./obj_dir/Vvideo_ctrl_tb | tee /dev/stderr | grep "All tests passed!" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* test/video_ctrl_checker.sv */
// testbench checker comparing handshake, raster counters, interrupt and pixel address with a model
module video_ctrl_checker (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   port_req,
    input  logic                   port_ack,
    input  video_pkg::video_regs_t regs,
    input  video_pkg::coord_t      hcount,
    input  video_pkg::coord_t      vcount,
    input  logic                   frame_int,
    input  video_pkg::pix_addr_t   pix_addr,
    input  logic                   chk_en,
    input  video_pkg::byte_t       chk_fld,
    input  video_pkg::coord_t      chk_want,
    input  logic                   done,
    output int                     errors
);

    video_pkg::video_regs_t p_regs;
    video_pkg::coord_t      p_h;
    video_pkg::coord_t      p_v;
    logic                   p_rst = 1'b0;
    logic                   p_req = 1'b0;
    logic                   p_ack = 1'b0;
    logic                   p_hit = 1'b0;
    logic                   p_done = 1'b0;
    int                     int_left, chg, tests, n_wr, bad, bad_int, bad_pix, bad_cnt, samples;
    int                     sx, sy, exp_h, exp_v;
    int                     seed = 36563;

    // maps the register index of a table entry to its field with 9-bit pairs under the low index
    function automatic video_pkg::coord_t field_value(input video_pkg::video_regs_t r,
                                                     input video_pkg::byte_t f);
        case (f)
            video_pkg::reg_vpage:   return {1'b0, r.vpage};
            video_pkg::reg_vconf:   return {1'b0, r.vconf};
            video_pkg::reg_gx_l:    return r.gx_offs;
            video_pkg::reg_gy_l:    return r.gy_offs;
            video_pkg::reg_tsconf:  return {1'b0, r.tsconf};
            video_pkg::reg_palsel:  return {1'b0, r.palsel};
            video_pkg::reg_border:  return {1'b0, r.border};
            video_pkg::reg_tmpage:  return {1'b0, r.tmpage};
            video_pkg::reg_t0gpage: return {1'b0, r.t0gpage};
            video_pkg::reg_t1gpage: return {1'b0, r.t1gpage};
            video_pkg::reg_sgpage:  return {1'b0, r.sgpage};
            video_pkg::reg_t0x_l:   return r.t0x_offs;
            video_pkg::reg_t0y_l:   return r.t0y_offs;
            video_pkg::reg_t1x_l:   return r.t1x_offs;
            video_pkg::reg_t1y_l:   return r.t1y_offs;
            video_pkg::reg_hint:    return {1'b0, r.hint_beg};
            video_pkg::reg_vint_l:  return r.vint_beg;
            default:                return 9'h1FF;
        endcase
    endfunction

    task automatic compare(input string name, input int want, input int got, inout int fails);
        if (want != got)
        begin
            errors++;
            fails++;
            $display("Mismatch at %0t: %s expected %0h, got %0h", $time, name, want, got);
        end
    endtask

    task automatic protocol_error(input string what);
        errors++;
        bad++;
        $display("Error at %0t: %s", $time, what);
    endtask

    task automatic finish_test(input string name, input int fails);
        tests++;
        $display("%s: %s", name, fails == 0 ? "ok" : "FAILED");
    endtask

    always @(negedge clk)
    begin
        if (!rst_n)
        begin
            p_hit    = 1'b0;
            int_left = 0;
        end
        else
        begin
            if (!p_rst)
            begin
                compare("regs.vpage", 5, int'(regs.vpage), bad);
                compare("regs.palsel", 15, int'(regs.palsel), bad);
                compare("regs.hint_beg", 2, int'(regs.hint_beg), bad);
                compare("regs.gx_offs", 0, int'(regs.gx_offs), bad);
                compare("regs.gy_offs", 0, int'(regs.gy_offs), bad);
                compare("regs.t0x_offs", 0, int'(regs.t0x_offs), bad);
                compare("regs.t0y_offs", 0, int'(regs.t0y_offs), bad);
                compare("regs.t1x_offs", 0, int'(regs.t1x_offs), bad);
                compare("regs.t1y_offs", 0, int'(regs.t1y_offs), bad);
                compare("port_ack", 0, int'(port_ack), bad);
                compare("hcount", 0, int'(hcount), bad);
                compare("vcount", 0, int'(vcount), bad);
                finish_test("reset defaults", bad);
                bad = 0;
            end
            else
            begin
                // the line advances only when the column wraps from the last column
                exp_h = int'(p_h) + 1;
                exp_v = int'(p_v);
                if (exp_h == video_pkg::h_total)
                begin
                    exp_h = 0;
                    exp_v = (exp_v + 1) % video_pkg::v_total;
                end
                compare("hcount", exp_h, int'(hcount), bad_cnt);
                compare("vcount", exp_v, int'(vcount), bad_cnt);
            end
            if (port_ack && !p_ack && !p_req)
                protocol_error("port_ack rose without a pending port_req");
            if (!port_ack && p_ack && p_req)
                protocol_error("port_ack dropped while port_req was still held");
            if (port_req && !p_req)
                chg = 0;  // a new port cycle starts
            if (regs != p_regs)
                chg++;
            if (!port_ack && p_ack && chg > 1)
                protocol_error("one port cycle changed the registers more than once");
            if (chk_en)
            begin
                n_wr++;
                compare($sformatf("regs index %02h", chk_fld), int'(chk_want),
                        int'(field_value(regs, chk_fld)), bad);
                finish_test($sformatf("port write %0d", n_wr), bad);
                bad = 0;
            end

            // interrupt position matched in the previous cycle starts a pulse of int_len cycles
            if (p_hit)
            begin
                int_left = video_pkg::int_len;
                bad_int  = 0;
            end
            compare("frame_int", (int_left > 0) ? 1 : 0, int'(frame_int), bad_int);
            if (int_left == 1)
                finish_test($sformatf("frame interrupt at line %0d", p_regs.vint_beg), bad_int);
            if (int_left > 0)
                int_left--;
            p_hit = (vcount == regs.vint_beg) && (int'(hcount) == 2 * int'(regs.hint_beg));

            if (p_rst && ($random(seed) & 7) == 0)
            begin
                sx = (int'(p_h) + int'(p_regs.gx_offs)) % 512;
                sy = (int'(p_v) + int'(p_regs.gy_offs)) % 512;
                samples++;
                compare("pix_addr", (int'(p_regs.vpage) << 17) | (sy << 8) | (sx >> 1),
                        int'(pix_addr), bad_pix);
            end
            if (done && !p_done)
            begin
                finish_test("raster counters", bad_cnt);
                finish_test($sformatf("pixel address over %0d sampled cycles", samples), bad_pix);
                $display("%0d tests run, %0d errors", tests, errors);
            end
        end
        p_regs = regs;
        p_h    = hcount;
        p_v    = vcount;
        p_rst  = rst_n;
        p_req  = port_req;
        p_ack  = port_ack;
        p_done = done;
    end

endmodule

/* test/video_ctrl_tb.sv */
// testbench top that applies a table of CPU port writes as four-phase cycles and runs the checker
module video_ctrl_tb;

    typedef struct packed {
        video_pkg::port_addr_t addr;
        video_pkg::byte_t      data;
        video_pkg::byte_t      fld;   // register index naming the field to check
        video_pkg::coord_t     want;
    } step_t;

    logic                   clk = 1'b0;
    logic                   rst_n, port_req, port_ack, frame_int, chk_en, done, ok;
    video_pkg::port_addr_t  port_addr;
    video_pkg::byte_t       port_data, chk_fld;
    video_pkg::coord_t      hcount, vcount, chk_want;
    video_pkg::video_regs_t regs;
    video_pkg::pix_addr_t   pix_addr;
    step_t                  steps [29];
    int                     errors;

    always #10 clk = ~clk;

    video_ctrl_top UUT (.*);

    video_ctrl_checker u_check (.*);

    // samples on falling edges until the chosen signal reaches level or the limit runs out
    task automatic wait_level(input bit use_int, input logic level, input int limit);
        int n = 0;
        @(negedge clk);
        while ((use_int ? frame_int : port_ack) != level && n < limit)
        begin
            @(negedge clk);
            n++;
        end
        if ((use_int ? frame_int : port_ack) != level)
        begin
            ok = 1'b0;
            $display("Timeout at %0t: %s did not reach %0d within %0d cycles", $time,
                     use_int ? "frame_int" : "port_ack", level, limit);
        end
    endtask

    initial
    begin
        rst_n     <= 1'b0;
        port_req  <= 1'b0;
        port_addr <= '0;
        port_data <= '0;
        chk_en    <= 1'b0;
        chk_fld   <= '0;
        chk_want  <= '0;
        done      <= 1'b0;
        ok        = 1'b1;
        steps[0]  = '{16'h01AF, 8'h12, video_pkg::reg_vpage, 9'h012};
        steps[1]  = '{16'h02AF, 8'h34, video_pkg::reg_gx_l, 9'h034};
        steps[2]  = '{16'h03AF, 8'hFF, video_pkg::reg_gx_l, 9'h134};
        steps[3]  = '{16'h04AF, 8'h56, video_pkg::reg_gy_l, 9'h056};
        steps[4]  = '{16'h05AF, 8'h02, video_pkg::reg_gy_l, 9'h056};  // only bit 0 reaches bit 8
        steps[5]  = '{16'h05AF, 8'h03, video_pkg::reg_gy_l, 9'h156};
        steps[6]  = '{16'h00AF, 8'h81, video_pkg::reg_vconf, 9'h081};
        steps[7]  = '{16'h06AF, 8'hE5, video_pkg::reg_tsconf, 9'h0E5};
        steps[8]  = '{16'h07AF, 8'h3C, video_pkg::reg_palsel, 9'h03C};
        steps[9]  = '{16'h0FAF, 8'h9A, video_pkg::reg_border, 9'h09A};
        steps[10] = '{16'h16AF, 8'h11, video_pkg::reg_tmpage, 9'h011};
        steps[11] = '{16'h40AF, 8'h0A, video_pkg::reg_t0x_l, 9'h00A};
        steps[12] = '{16'h41AF, 8'hFE, video_pkg::reg_t0x_l, 9'h00A};
        steps[13] = '{16'h46AF, 8'h0D, video_pkg::reg_t1y_l, 9'h00D};
        steps[14] = '{16'h47AF, 8'h01, video_pkg::reg_t1y_l, 9'h10D};
        steps[15] = '{16'h12FE, 8'hFB, video_pkg::reg_border, 9'h0F3};  // classic border
        steps[16] = '{16'h7FFD, 8'h08, video_pkg::reg_vpage, 9'h007};   // classic page
        steps[17] = '{16'h7FFD, 8'hF7, video_pkg::reg_vpage, 9'h005};
        steps[18] = '{16'h55AF, 8'hAA, video_pkg::reg_border, 9'h0F3};  // unknown index
        steps[19] = '{16'h23AF, 8'h05, video_pkg::reg_vint_l, 9'h005};
        steps[20] = '{16'h24AF, 8'h00, video_pkg::reg_vint_l, 9'h005};
        steps[21] = '{16'h22AF, 8'h10, video_pkg::reg_hint, 9'h010};
        steps[22] = '{16'h01AF, 8'hA5, video_pkg::reg_vpage, 9'h0A5};
        steps[23] = '{16'h1234, 8'h77, video_pkg::reg_vpage, 9'h0A5};  // no port at all
        steps[24] = '{16'h42AF, 8'h21, video_pkg::reg_t0y_l, 9'h021};
        steps[25] = '{16'h45AF, 8'h03, video_pkg::reg_t1x_l, 9'h100};
        steps[26] = '{16'h17AF, 8'h22, video_pkg::reg_t0gpage, 9'h022};
        steps[27] = '{16'h18AF, 8'h33, video_pkg::reg_t1gpage, 9'h033};
        steps[28] = '{16'h19AF, 8'h44, video_pkg::reg_sgpage, 9'h044};
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < $size(steps) && ok; i++)
        begin
            @(posedge clk);
            port_addr <= steps[i].addr;
            port_data <= steps[i].data;
            port_req  <= 1'b1;
            wait_level(1'b0, 1'b1, 20);
            @(posedge clk);
            port_req <= 1'b0;
            wait_level(1'b0, 1'b0, 20);
            @(posedge clk);
            chk_fld  <= steps[i].fld;
            chk_want <= steps[i].want;
            chk_en   <= 1'b1;
            @(posedge clk);
            chk_en <= 1'b0;
        end
        if (ok)
            wait_level(1'b1, 1'b0, 100);
        // two interrupts a frame apart take the line counter through its wrap
        for (int f = 0; f < 2 && ok; f++)
        begin
            wait_level(1'b1, 1'b1, 2 * video_pkg::h_total * video_pkg::v_total);
            if (ok)
                wait_level(1'b1, 1'b0, 100);
        end
        repeat (300) @(posedge clk);  // more cycles for the pixel address sample
        done <= 1'b1;
        repeat (2) @(posedge clk);
        if (ok && errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

/* verilog/port_decoder.sv */
// four-phase req/ack port slave, turns each CPU write cycle into a single write strobe
module port_decoder (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  port_req,
    input  video_pkg::port_addr_t port_addr,
    input  video_pkg::byte_t      port_data,
    output logic                  port_ack,
    output video_pkg::port_wr_t   wr
);

    typedef enum logic [1:0] {
        idle,
        ack,
        wait_release
    } state_t;

    state_t              state;
    video_pkg::port_wr_t dec;

    always_comb
    begin
        dec      = '0;
        dec.data = port_data;
        if (port_addr[7:0] == video_pkg::port_ts_lo)
        begin
            case (port_addr[15:8])
                video_pkg::reg_vconf:   dec.vconf_wr     = 1'b1;
                video_pkg::reg_vpage:   dec.vpage_wr     = 1'b1;
                video_pkg::reg_gx_l:    dec.gx_offsl_wr  = 1'b1;
                video_pkg::reg_gx_h:    dec.gx_offsh_wr  = 1'b1;
                video_pkg::reg_gy_l:    dec.gy_offsl_wr  = 1'b1;
                video_pkg::reg_gy_h:    dec.gy_offsh_wr  = 1'b1;
                video_pkg::reg_tsconf:  dec.tsconf_wr    = 1'b1;
                video_pkg::reg_palsel:  dec.palsel_wr    = 1'b1;
                video_pkg::reg_border:  dec.border_wr    = 1'b1;
                video_pkg::reg_tmpage:  dec.tmpage_wr    = 1'b1;
                video_pkg::reg_t0gpage: dec.t0gpage_wr   = 1'b1;
                video_pkg::reg_t1gpage: dec.t1gpage_wr   = 1'b1;
                video_pkg::reg_sgpage:  dec.sgpage_wr    = 1'b1;
                video_pkg::reg_hint:    dec.hint_beg_wr  = 1'b1;
                video_pkg::reg_vint_l:  dec.vint_begl_wr = 1'b1;
                video_pkg::reg_vint_h:  dec.vint_begh_wr = 1'b1;
                video_pkg::reg_t0x_l:   dec.t0x_offsl_wr = 1'b1;
                video_pkg::reg_t0x_h:   dec.t0x_offsh_wr = 1'b1;
                video_pkg::reg_t0y_l:   dec.t0y_offsl_wr = 1'b1;
                video_pkg::reg_t0y_h:   dec.t0y_offsh_wr = 1'b1;
                video_pkg::reg_t1x_l:   dec.t1x_offsl_wr = 1'b1;
                video_pkg::reg_t1x_h:   dec.t1x_offsh_wr = 1'b1;
                video_pkg::reg_t1y_l:   dec.t1y_offsl_wr = 1'b1;
                video_pkg::reg_t1y_h:   dec.t1y_offsh_wr = 1'b1;
                default: ;  // unknown index is still acknowledged
            endcase
        end
        else if (port_addr == video_pkg::port_zx_page)
            dec.zvpage_wr = 1'b1;
        else if (port_addr[7:0] == video_pkg::port_zx_border)
            dec.zborder_wr = 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state    <= idle;
            port_ack <= 1'b0;
            wr       <= '0;
        end
        else
        begin
            wr <= '0;  // strobes never last more than one cycle
            case (state)
                idle:
                    if (port_req)
                    begin
                        state    <= ack;
                        port_ack <= 1'b1;
                        wr       <= dec;
                    end
                ack:
                    if (port_req)
                        state <= wait_release;
                    else
                    begin
                        state    <= idle;
                        port_ack <= 1'b0;
                    end
                wait_release:
                    if (!port_req)
                    begin
                        state    <= idle;
                        port_ack <= 1'b0;
                    end
                default:
                    state <= idle;
            endcase
        end
    end

endmodule

/* verilog/raster_timer.sv */
// frame column and line counters with the programmable frame interrupt pulse
module raster_timer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  video_pkg::video_regs_t regs,
    output video_pkg::coord_t      hcount,
    output video_pkg::coord_t      vcount,
    output logic                   frame_int
);

    video_pkg::int_cnt_t int_cnt;
    logic                h_last;
    logic                v_last;
    logic                int_hit;

    assign h_last  = (hcount == video_pkg::coord_t'(video_pkg::h_total - 1));
    assign v_last  = (vcount == video_pkg::coord_t'(video_pkg::v_total - 1));
    // hint_beg counts column pairs
    assign int_hit = (vcount == regs.vint_beg) && (hcount == {regs.hint_beg, 1'b0});

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            hcount <= '0;
            vcount <= '0;
        end
        else if (h_last)
        begin
            hcount <= '0;
            if (v_last)
                vcount <= '0;
            else
                vcount <= vcount + 9'd1;
        end
        else
            hcount <= hcount + 9'd1;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            frame_int <= 1'b0;
            int_cnt   <= '0;
        end
        else if (int_hit)
        begin
            frame_int <= 1'b1;
            int_cnt   <= video_pkg::int_cnt_t'(video_pkg::int_len - 1);  // remaining high cycles
        end
        else if (int_cnt != '0)
            int_cnt <= int_cnt - video_pkg::int_cnt_t'(1);
        else
            frame_int <= 1'b0;
    end

endmodule

/* verilog/scroll_addr.sv */
// scrolled pixel fetch address built from the raster position, scroll offsets and video page
module scroll_addr (
    input  logic                   clk,
    input  logic                   rst_n,
    input  video_pkg::video_regs_t regs,
    input  video_pkg::coord_t      hcount,
    input  video_pkg::coord_t      vcount,
    output video_pkg::pix_addr_t   pix_addr
);

    video_pkg::coord_t scr_x;
    video_pkg::coord_t scr_y;

    assign scr_x = hcount + regs.gx_offs;  // both sums wrap at 512
    assign scr_y = vcount + regs.gy_offs;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            pix_addr <= '0;
        else
            pix_addr <= {regs.vpage, scr_y, scr_x[8:1]};  // fetch unit is a column pair
    end

endmodule

/* verilog/video_ctrl_top.sv */
// video control top level, port decoding, register file, raster timing and scroll addressing
module video_ctrl_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   port_req,
    input  video_pkg::port_addr_t  port_addr,
    input  video_pkg::byte_t       port_data,
    output logic                   port_ack,
    output video_pkg::video_regs_t regs,
    output video_pkg::coord_t      hcount,
    output video_pkg::coord_t      vcount,
    output logic                   frame_int,
    output video_pkg::pix_addr_t   pix_addr
);

    video_pkg::port_wr_t wr;  // one strobe per CPU port cycle

    port_decoder u_port_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .port_req  (port_req),
        .port_addr (port_addr),
        .port_data (port_data),
        .port_ack  (port_ack),
        .wr        (wr)
    );

    video_ports u_video_ports (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (wr),
        .regs  (regs)
    );

    raster_timer u_raster_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .regs      (regs),
        .hcount    (hcount),
        .vcount    (vcount),
        .frame_int (frame_int)
    );

    scroll_addr u_scroll_addr (
        .clk      (clk),
        .rst_n    (rst_n),
        .regs     (regs),
        .hcount   (hcount),
        .vcount   (vcount),
        .pix_addr (pix_addr)
    );

endmodule

/* verilog/video_pkg.sv */
// shared frame constants, port map, vector types and structs for the video control blocks
package video_pkg;

    typedef logic [15:0] port_addr_t;
    typedef logic [7:0]  byte_t;
    typedef logic [8:0]  coord_t;     // offsets, raster counters and line positions
    typedef logic [24:0] pix_addr_t;  // page, line, column pair

    localparam int h_total   = 448;  // columns per line
    localparam int v_total   = 320;  // lines per frame
    localparam int int_len   = 32;
    localparam int int_cnt_w = $clog2(int_len);

    typedef logic [int_cnt_w-1:0] int_cnt_t;

    localparam byte_t      port_ts_lo     = 8'hAF;  // high address byte is the register index
    localparam byte_t      port_zx_border = 8'hFE;
    localparam port_addr_t port_zx_page   = 16'h7FFD;

    localparam byte_t reg_vconf   = 8'h00;
    localparam byte_t reg_vpage   = 8'h01;
    localparam byte_t reg_gx_l    = 8'h02;
    localparam byte_t reg_gx_h    = 8'h03;
    localparam byte_t reg_gy_l    = 8'h04;
    localparam byte_t reg_gy_h    = 8'h05;
    localparam byte_t reg_tsconf  = 8'h06;
    localparam byte_t reg_palsel  = 8'h07;
    localparam byte_t reg_border  = 8'h0F;
    localparam byte_t reg_tmpage  = 8'h16;
    localparam byte_t reg_t0gpage = 8'h17;
    localparam byte_t reg_t1gpage = 8'h18;
    localparam byte_t reg_sgpage  = 8'h19;
    localparam byte_t reg_hint    = 8'h22;
    localparam byte_t reg_vint_l  = 8'h23;
    localparam byte_t reg_vint_h  = 8'h24;
    localparam byte_t reg_t0x_l   = 8'h40;
    localparam byte_t reg_t0x_h   = 8'h41;
    localparam byte_t reg_t0y_l   = 8'h42;
    localparam byte_t reg_t0y_h   = 8'h43;
    localparam byte_t reg_t1x_l   = 8'h44;
    localparam byte_t reg_t1x_h   = 8'h45;
    localparam byte_t reg_t1y_l   = 8'h46;
    localparam byte_t reg_t1y_h   = 8'h47;

    typedef struct packed {
        logic  zborder_wr;
        logic  border_wr;
        logic  zvpage_wr;
        logic  vpage_wr;
        logic  vconf_wr;
        logic  gx_offsl_wr, gx_offsh_wr;
        logic  gy_offsl_wr, gy_offsh_wr;
        logic  t0x_offsl_wr, t0x_offsh_wr;
        logic  t0y_offsl_wr, t0y_offsh_wr;
        logic  t1x_offsl_wr, t1x_offsh_wr;
        logic  t1y_offsl_wr, t1y_offsh_wr;
        logic  tsconf_wr;
        logic  palsel_wr;
        logic  tmpage_wr, t0gpage_wr, t1gpage_wr, sgpage_wr;
        logic  hint_beg_wr;
        logic  vint_begl_wr, vint_begh_wr;
        byte_t data;
    } port_wr_t;

    typedef struct packed {
        byte_t  border;
        byte_t  vpage;
        byte_t  vconf;
        coord_t gx_offs;
        coord_t gy_offs;
        coord_t t0x_offs;
        coord_t t0y_offs;
        coord_t t1x_offs;
        coord_t t1y_offs;
        byte_t  palsel;
        byte_t  hint_beg;  // in units of two columns
        coord_t vint_beg;
        byte_t  tsconf;
        byte_t  tmpage;
        byte_t  t0gpage;
        byte_t  t1gpage;
        byte_t  sgpage;
    } video_regs_t;

endpackage

/* verilog/video_ports.sv */
// video parameter register file, latches the port data byte on each decoded write strobe
module video_ports (
    input  logic                   clk,
    input  logic                   rst_n,
    input  video_pkg::port_wr_t    wr,
    output video_pkg::video_regs_t regs
);

    // border, the tile and sprite pages and the low tsconf bits keep their value over reset
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            regs.vpage       <= 8'h05;
            regs.vconf       <= 8'h00;
            regs.gx_offs     <= 9'd0;
            regs.gy_offs     <= 9'd0;
            regs.t0x_offs    <= 9'd0;
            regs.t0y_offs    <= 9'd0;
            regs.t1x_offs    <= 9'd0;
            regs.t1y_offs    <= 9'd0;
            regs.tsconf[7:5] <= 3'b000;
            regs.palsel      <= 8'h0F;
            regs.hint_beg    <= 8'd2;  // pentagon timing default
            regs.vint_beg    <= 9'd0;
        end
        else
        begin
            if (wr.zborder_wr)   regs.border        <= {5'b11110, wr.data[2:0]};
            if (wr.border_wr)    regs.border        <= wr.data;
            if (wr.zvpage_wr)    regs.vpage         <= {6'b000001, wr.data[3], 1'b1};
            if (wr.vpage_wr)     regs.vpage         <= wr.data;
            if (wr.vconf_wr)     regs.vconf         <= wr.data;
            if (wr.gx_offsl_wr)  regs.gx_offs[7:0]  <= wr.data;
            if (wr.gx_offsh_wr)  regs.gx_offs[8]    <= wr.data[0];
            if (wr.gy_offsl_wr)  regs.gy_offs[7:0]  <= wr.data;
            if (wr.gy_offsh_wr)  regs.gy_offs[8]    <= wr.data[0];
            if (wr.t0x_offsl_wr) regs.t0x_offs[7:0] <= wr.data;
            if (wr.t0x_offsh_wr) regs.t0x_offs[8]   <= wr.data[0];
            if (wr.t0y_offsl_wr) regs.t0y_offs[7:0] <= wr.data;
            if (wr.t0y_offsh_wr) regs.t0y_offs[8]   <= wr.data[0];
            if (wr.t1x_offsl_wr) regs.t1x_offs[7:0] <= wr.data;
            if (wr.t1x_offsh_wr) regs.t1x_offs[8]   <= wr.data[0];
            if (wr.t1y_offsl_wr) regs.t1y_offs[7:0] <= wr.data;
            if (wr.t1y_offsh_wr) regs.t1y_offs[8]   <= wr.data[0];
            if (wr.tsconf_wr)    regs.tsconf        <= wr.data;
            if (wr.palsel_wr)    regs.palsel        <= wr.data;
            if (wr.tmpage_wr)    regs.tmpage        <= wr.data;
            if (wr.t0gpage_wr)   regs.t0gpage       <= wr.data;
            if (wr.t1gpage_wr)   regs.t1gpage       <= wr.data;
            if (wr.sgpage_wr)    regs.sgpage        <= wr.data;
            if (wr.hint_beg_wr)  regs.hint_beg      <= wr.data;
            if (wr.vint_begl_wr) regs.vint_beg[7:0] <= wr.data;
            if (wr.vint_begh_wr) regs.vint_beg[8]   <= wr.data[0];
        end
    end

endmodule
